/* eeprom_pkg.sv */
package eeprom_pkg;

    // widths of the EEPROM address and data paths
    localparam int ADDR_W = 11;
    localparam int DATA_W = 8;

    // byte address into the 2 KB array
    // bits 10:8 are the block select sent in the control byte
    typedef logic [ADDR_W-1:0] addr_t;

    // one data byte, host side and serial side
    typedef logic [DATA_W-1:0] byte_t;

    // operations carried out by the bit-level engine
    typedef enum logic [1:0]
    {
        OP_START,   // start, or repeated start
        OP_STOP,
        OP_WRITE,   // byte out, then sample ack
        OP_READ     // byte in, then nack
    } bus_op_t;

    // device type code in the upper nibble of every control byte
    localparam logic [3:0] CTRL_TAG = 4'b1010;

endpackage

/* cmd_fifo.sv */
`timescale 1ns/10ps

module cmd_fifo
#(
    parameter int FIFO_DEPTH = 4
)
(
    input  logic              CLK,
    input  logic              RESET,
    input  logic              push_wr,
    input  logic              push_rd,
    input  eeprom_pkg::addr_t push_addr,
    input  eeprom_pkg::byte_t push_data,
    input  logic              pop,
    output logic              full,
    output logic              empty,
    output logic              q_rd,
    output eeprom_pkg::addr_t q_addr,
    output eeprom_pkg::byte_t q_data
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam logic [PTR_W:0] FULL_CNT = (PTR_W+1)'(FIFO_DEPTH);

    logic              rd_mem   [FIFO_DEPTH];
    eeprom_pkg::addr_t addr_mem [FIFO_DEPTH];
    eeprom_pkg::byte_t data_mem [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W:0]    count;
    logic              do_push;
    logic              do_pop;

    assign do_push = (push_wr | push_rd) & ~full;   // dropped while full
    assign do_pop  = pop & ~empty;

    always_ff @(posedge CLK)
    begin
        if (do_push)
        begin
            rd_mem[wr_ptr]   <= ~push_wr;   // wr wins when both strobes are high
            addr_mem[wr_ptr] <= push_addr;
            data_mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + PTR_W'(1);   // depth is a power of two, wraps
            if (do_pop)
                rd_ptr <= rd_ptr + PTR_W'(1);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign full   = (count == FULL_CNT);
    assign empty  = (count == '0);
    assign q_rd   = rd_mem[rd_ptr];
    assign q_addr = addr_mem[rd_ptr];
    assign q_data = data_mem[rd_ptr];

endmodule

/* bus_engine.sv */
`timescale 1ns/10ps

module bus_engine
#(
    parameter int SCL_HALF = 4
)
(
    input  logic                CLK,
    input  logic                RESET,
    input  logic                op_start,
    input  eeprom_pkg::bus_op_t op,
    input  eeprom_pkg::byte_t   tx_byte,
    input  logic                sda_in,
    output logic                busy,
    output logic                op_done,
    output logic                got_ack,
    output eeprom_pkg::byte_t   rx_byte,
    output logic                scl,
    output logic                sda_oe
);

    localparam int CNT_W = $clog2(SCL_HALF) + 1;
    localparam logic [CNT_W-1:0] HALF_END = CNT_W'(SCL_HALF - 1);
    localparam logic [CNT_W-1:0] HALF_MID = CNT_W'(SCL_HALF / 2);

    eeprom_pkg::bus_op_t op_q;
    eeprom_pkg::bus_op_t cur_op;
    eeprom_pkg::byte_t   sr;         // tx bits out of bit 7, rx bits into bit 0
    logic [CNT_W-1:0]    cnt;
    logic [4:0]          half;       // half period index within the operation
    logic [4:0]          nxt_half;
    logic [4:0]          last_half;
    logic                is_byte;
    logic                nxt_scl;
    logic                nxt_oe;

    assign is_byte = (op_q == eeprom_pkg::OP_WRITE) || (op_q == eeprom_pkg::OP_READ);

    // line levels for the half period about to begin
    always_comb
    begin
        cur_op    = busy ? op_q : op;
        nxt_half  = busy ? half + 5'd1 : 5'd0;
        last_half = is_byte ? 5'd17 : 5'd1;
        nxt_scl   = scl;
        nxt_oe    = sda_oe;
        case (cur_op)
            eeprom_pkg::OP_START:
                case (nxt_half)
                    5'd0:
                    begin
                        nxt_scl = 1'b1;
                        nxt_oe  = 1'b0;
                    end
                    5'd1:
                    begin
                        nxt_scl = 1'b1;
                        nxt_oe  = 1'b1;   // sda falls with scl high
                    end
                    default:
                    begin
                        nxt_scl = 1'b0;
                        nxt_oe  = 1'b1;
                    end
                endcase
            eeprom_pkg::OP_STOP:
                case (nxt_half)
                    5'd0:
                    begin
                        nxt_scl = 1'b0;
                        nxt_oe  = 1'b1;
                    end
                    5'd1:
                    begin
                        nxt_scl = 1'b1;
                        nxt_oe  = 1'b1;
                    end
                    default:
                    begin
                        nxt_scl = 1'b1;
                        nxt_oe  = 1'b0;   // sda rises with scl high
                    end
                endcase
            default:
            begin
                if (nxt_half > 5'd17)
                begin
                    nxt_scl = 1'b0;
                    nxt_oe  = 1'b0;
                end
                else if (nxt_half[0])
                    nxt_scl = 1'b1;   // high half, sda holds
                else
                begin
                    nxt_scl = 1'b0;
                    if (cur_op == eeprom_pkg::OP_READ || nxt_half[4:1] == 4'd8)
                        nxt_oe = 1'b0;   // released for ack, rx bits or nack
                    else
                        nxt_oe = busy ? ~sr[7] : ~tx_byte[7];
                end
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy    <= 1'b0;
            op_done <= 1'b0;
            scl     <= 1'b1;
            sda_oe  <= 1'b0;
            cnt     <= '0;
            half    <= '0;
        end
        else
        begin
            op_done <= 1'b0;
            if (!busy)
            begin
                if (op_start)
                begin
                    busy   <= 1'b1;
                    cnt    <= '0;
                    half   <= '0;
                    scl    <= nxt_scl;
                    sda_oe <= nxt_oe;
                end
            end
            else if (cnt == HALF_END)
            begin
                cnt    <= '0;
                half   <= nxt_half;
                scl    <= nxt_scl;
                sda_oe <= nxt_oe;
                if (half == last_half)
                begin
                    busy    <= 1'b0;
                    op_done <= 1'b1;
                end
            end
            else
                cnt <= cnt + 1'b1;
        end
    end

    // sampling in the middle of scl high
    always_ff @(posedge CLK)
    begin
        if (!busy && op_start)
        begin
            op_q <= op;
            sr   <= tx_byte;
        end
        else if (busy && is_byte && scl && cnt == HALF_MID)
        begin
            if (half[4:1] < 4'd8)
                sr <= {sr[6:0], sda_in};
            else if (op_q == eeprom_pkg::OP_WRITE)
                got_ack <= ~sda_in;
        end
    end

    assign rx_byte = sr;

endmodule

/* eeprom_seq.sv */
`timescale 1ns/10ps

module eeprom_seq
(
    input  logic                CLK,
    input  logic                RESET,
    input  logic                empty,
    input  logic                q_rd,
    input  eeprom_pkg::addr_t   q_addr,
    input  eeprom_pkg::byte_t   q_data,
    input  logic                busy,
    input  logic                op_done,
    input  logic                got_ack,
    input  eeprom_pkg::byte_t   rx_byte,
    output logic                pop,
    output logic                op_start,
    output eeprom_pkg::bus_op_t op,
    output eeprom_pkg::byte_t   tx_byte,
    output logic                done,
    output logic                nack,
    output logic                rd_valid,
    output eeprom_pkg::byte_t   rd_data
);

    typedef enum logic [3:0]
    {
        S_IDLE,
        S_START,
        S_CTRL_WR,
        S_ADDR,
        S_DATA_WR,
        S_RESTART,
        S_CTRL_RD,
        S_DATA_RD,
        S_STOP,
        S_FINISH
    } state_t;

    state_t              state;
    state_t              next_state;
    logic                issued;      // op of the current state handed to the engine
    logic                nack_flag;
    logic                ack_miss;
    logic                cmd_rd;
    eeprom_pkg::addr_t   cmd_addr;
    eeprom_pkg::byte_t   cmd_data;
    eeprom_pkg::byte_t   ctrl_wr;
    eeprom_pkg::byte_t   ctrl_rd;
    eeprom_pkg::bus_op_t op_sel;
    eeprom_pkg::byte_t   tx_sel;

    assign ctrl_wr = {eeprom_pkg::CTRL_TAG, cmd_addr[10:8], 1'b0};
    assign ctrl_rd = {eeprom_pkg::CTRL_TAG, cmd_addr[10:8], 1'b1};

    // operation per state and where to go once it is done
    always_comb
    begin
        op_sel     = eeprom_pkg::OP_WRITE;
        tx_sel     = cmd_data;
        next_state = S_STOP;
        ack_miss   = 1'b0;
        case (state)
            S_START:
            begin
                op_sel     = eeprom_pkg::OP_START;
                next_state = S_CTRL_WR;
            end
            S_CTRL_WR:
            begin
                tx_sel     = ctrl_wr;
                ack_miss   = ~got_ack;
                next_state = got_ack ? S_ADDR : S_STOP;
            end
            S_ADDR:
            begin
                tx_sel   = cmd_addr[7:0];
                ack_miss = ~got_ack;
                if (got_ack)
                    next_state = cmd_rd ? S_RESTART : S_DATA_WR;
            end
            S_DATA_WR:
                ack_miss = ~got_ack;
            S_RESTART:
            begin
                op_sel     = eeprom_pkg::OP_START;
                next_state = S_CTRL_RD;
            end
            S_CTRL_RD:
            begin
                tx_sel     = ctrl_rd;
                ack_miss   = ~got_ack;
                next_state = got_ack ? S_DATA_RD : S_STOP;
            end
            S_DATA_RD:
            begin
                op_sel = eeprom_pkg::OP_READ;
                tx_sel = 8'hff;
            end
            S_STOP:
            begin
                op_sel     = eeprom_pkg::OP_STOP;
                next_state = S_FINISH;
            end
            default:
                next_state = S_IDLE;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= S_IDLE;
            issued    <= 1'b0;
            nack_flag <= 1'b0;
            pop       <= 1'b0;
            op_start  <= 1'b0;
            done      <= 1'b0;
            nack      <= 1'b0;
            rd_valid  <= 1'b0;
        end
        else
        begin
            pop      <= 1'b0;
            op_start <= 1'b0;
            done     <= 1'b0;
            nack     <= 1'b0;
            rd_valid <= 1'b0;
            case (state)
                S_IDLE:
                    if (!empty)
                    begin
                        pop       <= 1'b1;
                        nack_flag <= 1'b0;
                        issued    <= 1'b0;
                        state     <= S_START;
                    end
                S_FINISH:
                begin
                    done     <= 1'b1;
                    nack     <= nack_flag;
                    rd_valid <= cmd_rd & ~nack_flag;
                    state    <= S_IDLE;
                end
                default:
                    if (!issued)
                    begin
                        if (!busy)
                        begin
                            op_start <= 1'b1;
                            issued   <= 1'b1;
                        end
                    end
                    else if (op_done)
                    begin
                        issued <= 1'b0;
                        state  <= next_state;
                        if (ack_miss)
                            nack_flag <= 1'b1;   // skip the rest, go to stop
                    end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == S_IDLE && !empty)
        begin
            cmd_rd   <= q_rd;
            cmd_addr <= q_addr;
            cmd_data <= q_data;
        end
        if (!issued && !busy && state != S_IDLE && state != S_FINISH)
        begin
            op      <= op_sel;
            tx_byte <= tx_sel;
        end
        if (state == S_DATA_RD && issued && op_done)
            rd_data <= rx_byte;   // held until the next read
    end

endmodule

/* eeprom_sys.sv */
`timescale 1ns/10ps

module eeprom_sys
#(
    parameter int SCL_HALF   = 4,
    parameter int FIFO_DEPTH = 4
)
(
    input  logic              CLK,
    input  logic              RESET,
    input  logic              wr,
    input  logic              rd,
    input  eeprom_pkg::addr_t addr,
    input  eeprom_pkg::byte_t wr_data,
    input  logic              sda_in,
    output logic              full,
    output logic              done,
    output logic              nack,
    output logic              rd_valid,
    output eeprom_pkg::byte_t rd_data,
    output logic              scl,
    output logic              sda_oe
);

    // fifo head to sequencer
    logic                empty;
    logic                pop;
    logic                q_rd;
    eeprom_pkg::addr_t   q_addr;
    eeprom_pkg::byte_t   q_data;

    // sequencer to engine
    logic                op_start;
    eeprom_pkg::bus_op_t op;
    eeprom_pkg::byte_t   tx_byte;
    logic                busy;
    logic                op_done;
    logic                got_ack;
    eeprom_pkg::byte_t   rx_byte;

    cmd_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) cmd_fifo_i
    (
        .CLK(CLK), .RESET(RESET),
        .push_wr(wr), .push_rd(rd), .push_addr(addr), .push_data(wr_data),
        .pop(pop), .full(full), .empty(empty),
        .q_rd(q_rd), .q_addr(q_addr), .q_data(q_data)
    );

    eeprom_seq eeprom_seq_i
    (
        .CLK(CLK), .RESET(RESET),
        .empty(empty), .q_rd(q_rd), .q_addr(q_addr), .q_data(q_data),
        .busy(busy), .op_done(op_done), .got_ack(got_ack), .rx_byte(rx_byte),
        .pop(pop), .op_start(op_start), .op(op), .tx_byte(tx_byte),
        .done(done), .nack(nack), .rd_valid(rd_valid), .rd_data(rd_data)
    );

    bus_engine #(.SCL_HALF(SCL_HALF)) bus_engine_i
    (
        .CLK(CLK), .RESET(RESET),
        .op_start(op_start), .op(op), .tx_byte(tx_byte), .sda_in(sda_in),
        .busy(busy), .op_done(op_done), .got_ack(got_ack), .rx_byte(rx_byte),
        .scl(scl), .sda_oe(sda_oe)
    );

endmodule

/* tb_eeprom_model.sv */
`timescale 1ns/10ps

module tb_eeprom_model
(
    input  logic       CLK,
    input  logic       RESET,
    input  logic       scl,
    input  logic       sda,
    input  logic       refuse,    // withhold every acknowledge
    input  logic [2:0] exp_blk,   // block of the command on the bus
    output logic       pull,      // pulls sda low
    output int         errs
);

    typedef enum logic [2:0] {M_IDLE, M_CTRL, M_ADDR, M_DATA, M_TX, M_WAIT} mode_t;

    eeprom_pkg::byte_t mem [2048];
    mode_t             mode;
    eeprom_pkg::byte_t sr;
    eeprom_pkg::byte_t txb;
    eeprom_pkg::addr_t ptr;
    logic [2:0]        blk;
    logic              scl_q;
    logic              sda_q;
    logic              acking;
    logic              in_frame;
    int                nbit;      // scl rising edges within the byte

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = eeprom_pkg::byte_t'(i) ^ eeprom_pkg::byte_t'(i >> 8) ^ 8'h5a;
    end

    // bus oversampled on the system clock
    always @(posedge CLK)
    begin
        scl_q <= scl;
        sda_q <= sda;
        if (RESET)
        begin
            mode     <= M_IDLE;
            pull     <= 1'b0;
            acking   <= 1'b0;
            in_frame <= 1'b0;
            nbit     <= 0;
            errs     <= 0;
        end
        else if (scl_q && scl && sda_q && !sda)
        begin
            mode     <= M_CTRL;   // start or repeated start
            in_frame <= 1'b1;
            nbit     <= 0;
            pull     <= 1'b0;
            acking   <= 1'b0;
        end
        else if (scl_q && scl && !sda_q && sda)
        begin
            assert (in_frame)
            else
            begin
                $display("ERR %0t: stop condition with no start before it", $time);
                errs <= errs + 1;
            end
            mode     <= M_IDLE;
            in_frame <= 1'b0;
            pull     <= 1'b0;
        end
        else if (!scl_q && scl && !acking)
        begin
            if (mode == M_TX && nbit == 8)
            begin
                assert (sda)
                else
                begin
                    $display("ERR %0t: single byte read not ended by a nack", $time);
                    errs <= errs + 1;
                end
                mode <= M_WAIT;
            end
            else if (mode inside {M_CTRL, M_ADDR, M_DATA} && nbit < 8)
                sr <= {sr[6:0], sda};
            if (nbit < 8)
                nbit <= nbit + 1;
        end
        else if (scl_q && !scl)
        begin
            if (acking)
            begin
                acking <= 1'b0;
                nbit   <= 0;
                txb    <= mem[ptr];
                pull   <= (mode == M_TX) ? ~mem[ptr][7] : 1'b0;   // first read bit
            end
            else if (mode == M_TX)
                pull <= (nbit < 8) ? ~txb[7 - nbit] : 1'b0;
            else if (mode inside {M_CTRL, M_ADDR, M_DATA} && nbit == 8)
            begin
                acking <= ~refuse;
                pull   <= ~refuse;
                mode   <= M_WAIT;
                case (mode)
                    M_CTRL:
                    begin
                        assert (sr[7:4] == eeprom_pkg::CTRL_TAG && sr[3:1] == exp_blk)
                        else
                        begin
                            $display("ERR %0t: control byte %02h, block expected %0d",
                                     $time, sr, exp_blk);
                            errs <= errs + 1;
                        end
                        blk <= sr[3:1];
                        if (!refuse)
                            mode <= sr[0] ? M_TX : M_ADDR;
                    end
                    M_ADDR:
                    begin
                        ptr <= {blk, sr};
                        if (!refuse)
                            mode <= M_DATA;
                    end
                    default:
                        if (!refuse)
                            mem[ptr] <= sr;
                endcase
            end
        end
    end

endmodule

/* tb_eeprom_sys.sv */
`timescale 1ns/10ps

module tb_eeprom_sys;

    localparam int SCL_HALF   = 4;
    localparam int FIFO_DEPTH = 4;
    localparam int WAIT_MAX   = 4000;   // clocks, enough for a full queue

    logic              CLK;
    logic              RESET;
    logic              wr;
    logic              rd;
    eeprom_pkg::addr_t addr;
    eeprom_pkg::byte_t wr_data;
    logic              sda_in;
    logic              full;
    logic              done;
    logic              nack;
    logic              rd_valid;
    eeprom_pkg::byte_t rd_data;
    logic              scl;
    logic              sda_oe;
    logic              slave_pull;
    logic              refuse;
    logic [2:0]        exp_blk;
    int                model_errs;

    eeprom_pkg::byte_t ref_mem [2048];
    logic [20:0]       cmd_q [$];   // {nack expected, read, addr, data or read value}
    logic [20:0]       head;
    eeprom_pkg::addr_t cur_addr;
    logic              accepted;
    int                seed;
    int                errs;
    int                timeouts;
    int                n_done;
    int                n_acc;
    int                base;

    eeprom_sys #(.SCL_HALF(SCL_HALF), .FIFO_DEPTH(FIFO_DEPTH)) eeprom_sys_i
    (
        .CLK(CLK), .RESET(RESET), .wr(wr), .rd(rd), .addr(addr), .wr_data(wr_data),
        .sda_in(sda_in), .full(full), .done(done), .nack(nack), .rd_valid(rd_valid),
        .rd_data(rd_data), .scl(scl), .sda_oe(sda_oe)
    );

    tb_eeprom_model eeprom_model_i
    (
        .CLK(CLK), .RESET(RESET), .scl(scl), .sda(sda_in), .refuse(refuse),
        .exp_blk(exp_blk), .pull(slave_pull), .errs(model_errs)
    );

    assign sda_in = ~(sda_oe | slave_pull);   // wired-AND of both pull-downs

    always #5 CLK = ~CLK;

    always @(posedge CLK)
        exp_blk <= (cmd_q.size() != 0) ? cmd_q[0][18:16] : 3'd0;

    task automatic flag_error(input string msg);
        $display("ERR %0t: %s", $time, msg);
        errs++;
    endtask

    task automatic push_cmd(input logic is_rd, input eeprom_pkg::addr_t a,
                            input eeprom_pkg::byte_t d);
        @(posedge CLK);
        #1;
        wr       = ~is_rd;
        rd       = is_rd;
        addr     = a;
        wr_data  = d;
        accepted = ~full;
        if (accepted)
        begin
            if (is_rd)
                cmd_q.push_back({refuse, 1'b1, a, ref_mem[a]});
            else
            begin
                cmd_q.push_back({refuse, 1'b0, a, d});
                if (!refuse)
                    ref_mem[a] = d;
            end
        end
    endtask

    task automatic idle_bus();
        @(posedge CLK);
        #1;
        wr = 1'b0;
        rd = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (cmd_q.size() != 0 && n < WAIT_MAX)
        begin
            @(posedge CLK);
            n++;
        end
        if (cmd_q.size() != 0)
        begin
            $display("timeout at %0t: %0d commands never finished", $time, cmd_q.size());
            timeouts++;
            cmd_q.delete();
        end
    endtask

    // every done retires the oldest accepted command
    always @(posedge CLK)
    begin
        if (!RESET && done)
        begin
            n_done++;
            if (cmd_q.size() == 0)
                flag_error("done pulse with no command outstanding");
            else
            begin
                head = cmd_q.pop_front();
                assert (nack == head[20])
                else
                    flag_error($sformatf("nack %0b at addr %03h", nack, head[18:8]));
                assert (rd_valid == (head[19] & ~head[20]))
                else
                    flag_error($sformatf("rd_valid %0b at addr %03h", rd_valid, head[18:8]));
                assert (!rd_valid || rd_data == head[7:0])
                else
                    flag_error($sformatf("rd_data %02h at addr %03h, expected %02h",
                                         rd_data, head[18:8], head[7:0]));
            end
        end
        else if (!RESET)
            assert (!nack && !rd_valid) else flag_error("nack or rd_valid without done");
    end

    initial
    begin
        CLK      = 1'b0;
        RESET    = 1'b1;
        wr       = 1'b0;
        rd       = 1'b0;
        addr     = '0;
        wr_data  = '0;
        refuse   = 1'b0;
        seed     = 32'h4581e775;
        errs     = 0;
        timeouts = 0;
        n_done   = 0;
        for (int i = 0; i < 2048; i++)
            ref_mem[i] = eeprom_pkg::byte_t'(i) ^ eeprom_pkg::byte_t'(i >> 8) ^ 8'h5a;
        repeat (16) @(posedge CLK);
        #1;
        RESET = 1'b0;
        repeat (20) @(posedge CLK);
        #1;
        assert (scl && !sda_oe && !full) else flag_error("bus or full not idle after reset");

        // write then read back, one address in each block
        for (int b = 0; b < 8; b++)
        begin
            cur_addr = {b[2:0], eeprom_pkg::byte_t'($random(seed))};
            push_cmd(1'b0, cur_addr, eeprom_pkg::byte_t'($random(seed)));
            push_cmd(1'b1, cur_addr, 8'h00);
            idle_bus();
            wait_drain();
        end

        // mixed commands back to back on one address
        cur_addr = eeprom_pkg::addr_t'($random(seed));
        base     = n_done;
        n_acc    = 0;
        for (int k = 0; k < FIFO_DEPTH; k++)
        begin
            push_cmd(k[0], cur_addr, eeprom_pkg::byte_t'($random(seed)));
            n_acc += accepted;
        end
        idle_bus();
        wait_drain();
        assert (n_acc == FIFO_DEPTH && n_done - base == FIFO_DEPTH)
        else
            flag_error($sformatf("%0d done pulses for %0d queued commands", n_done - base, n_acc));

        // fill the queue behind a running write, one push too many
        base = n_done;
        push_cmd(1'b0, cur_addr, eeprom_pkg::byte_t'($random(seed)));
        idle_bus();
        repeat (4) @(posedge CLK);
        n_acc = 1;
        for (int k = 0; k <= FIFO_DEPTH; k++)
        begin
            push_cmd(k[0], {3'(k), cur_addr[7:0]}, eeprom_pkg::byte_t'($random(seed)));
            n_acc += accepted;
        end
        assert (full && !accepted) else flag_error("push accepted while the queue was full");
        idle_bus();
        wait_drain();
        assert (n_acc == FIFO_DEPTH + 1 && n_done - base == n_acc)
        else
            flag_error($sformatf("%0d done pulses for %0d accepted pushes", n_done - base, n_acc));

        // slave refuses, then a clean read shows memory untouched
        refuse = 1'b1;
        push_cmd(1'b0, cur_addr, ~ref_mem[cur_addr]);
        push_cmd(1'b1, cur_addr, 8'h00);
        idle_bus();
        wait_drain();
        refuse = 1'b0;
        push_cmd(1'b1, cur_addr, 8'h00);
        idle_bus();
        wait_drain();

        $display("errors: checks %0d, model %0d, timeouts %0d", errs, model_errs, timeouts);
        if (errs == 0 && model_errs == 0 && timeouts == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

/* eeprom_sys.f */
eeprom_pkg.sv
cmd_fifo.sv
bus_engine.sv
eeprom_seq.sv
eeprom_sys.sv
tb_eeprom_model.sv
tb_eeprom_sys.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_eeprom_sys -f eeprom_sys.f -o sim_eeprom_sys &&
./obj_dir/sim_eeprom_sys 2>&1 | tee /dev/stderr | grep "^Result: PASSED$" > /dev/null &&
echo "simulation run ok" ||
{ echo "simulation run not ok"; exit 1; }
